// ==== logic/core_cfg_pkg.sv ====
package core_cfg_pkg;

    typedef logic [5:0]  phy_reg_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [5:0]  rob_idx_t;

    // msb first: alu1, br, alu2, sp, then rf_we
    typedef logic [4:0]  op_flags_t;

    // bit positions inside op_flags_t
    localparam int OP_ALU1  = 4;
    localparam int OP_BR    = 3;
    localparam int OP_ALU2  = 2;
    localparam int OP_SP    = 1;
    localparam int OP_RF_WE = 0;

    // one register per tag value
    localparam int PHY_REGS = 2 ** $bits(phy_reg_t);

endpackage

// ==== logic/issue_bus_pkg.sv ====
package issue_bus_pkg;

    // renamed instruction from decode/rename
    typedef struct packed {
        logic                    valid;
        core_cfg_pkg::pc_t       pc;
        core_cfg_pkg::op_flags_t ops;
        core_cfg_pkg::phy_reg_t  phy_src1;
        core_cfg_pkg::phy_reg_t  phy_src2;
        core_cfg_pkg::phy_reg_t  phy_dest;
        core_cfg_pkg::rob_idx_t  rob_idx;
        logic                    src1_ready;
        logic                    src2_ready;
    } dispatch_t;

    // queue entry, same content as dispatch for now
    typedef struct packed {
        logic                    valid;
        core_cfg_pkg::pc_t       pc;
        core_cfg_pkg::op_flags_t ops;
        core_cfg_pkg::phy_reg_t  phy_src1;
        core_cfg_pkg::phy_reg_t  phy_src2;
        core_cfg_pkg::phy_reg_t  phy_dest;
        core_cfg_pkg::rob_idx_t  rob_idx;
        logic                    src1_ready;
        logic                    src2_ready;
    } iq_entry_t;

    // writeback broadcast
    typedef struct packed {
        logic                   rf_we;
        core_cfg_pkg::phy_reg_t dest;
        core_cfg_pkg::word_t    result;
    } wb_t;

    // picked instruction, held in the issue register
    typedef struct packed {
        logic                    valid;
        core_cfg_pkg::pc_t       pc;
        core_cfg_pkg::op_flags_t ops;
        core_cfg_pkg::phy_reg_t  phy_src1;
        core_cfg_pkg::phy_reg_t  phy_src2;
        core_cfg_pkg::phy_reg_t  phy_dest;
        core_cfg_pkg::rob_idx_t  rob_idx;
    } issue_slot_t;

    // to execute
    typedef struct packed {
        logic                    valid;
        core_cfg_pkg::pc_t       pc;
        core_cfg_pkg::op_flags_t ops;
        core_cfg_pkg::phy_reg_t  phy_dest;
        core_cfg_pkg::rob_idx_t  rob_idx;
        core_cfg_pkg::word_t     src1_value;
        core_cfg_pkg::word_t     src2_value;
    } exec_op_t;

endpackage

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ns

module issue_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,
    input  issue_bus_pkg::dispatch_t                dispatch1,
    input  issue_bus_pkg::dispatch_t                dispatch2,
    input  issue_bus_pkg::wb_t                      wb1,
    input  issue_bus_pkg::wb_t                      wb2,
    input  logic [IQ_DEPTH-1:0]                     grant1_mask,
    input  logic [IQ_DEPTH-1:0]                     grant2_mask,
    output issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] entries,
    output logic                                    allowin
);

    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] queue_q;
    issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] queue_next;
    issue_bus_pkg::iq_entry_t                enq1;
    issue_bus_pkg::iq_entry_t                enq2;
    logic [CNT_W-1:0]                        count_q;
    logic [CNT_W-1:0]                        count_next;
    logic [IQ_DEPTH-1:0]                     granted;
    logic [IQ_DEPTH-1:0]                     valid_vec;
    logic                                    take1;
    logic                                    take2;

    // tag zero never waits
    function automatic logic woken(
        input core_cfg_pkg::phy_reg_t tag,
        input issue_bus_pkg::wb_t     a,
        input issue_bus_pkg::wb_t     b
    );
        return (tag == '0) || (a.rf_we && a.dest == tag) || (b.rf_we && b.dest == tag);
    endfunction

    function automatic issue_bus_pkg::iq_entry_t to_entry(
        input issue_bus_pkg::dispatch_t d,
        input issue_bus_pkg::wb_t       a,
        input issue_bus_pkg::wb_t       b
    );
        issue_bus_pkg::iq_entry_t e;
        e.valid      = d.valid;
        e.pc         = d.pc;
        e.ops        = d.ops;
        e.phy_src1   = d.phy_src1;
        e.phy_src2   = d.phy_src2;
        e.phy_dest   = d.phy_dest;
        e.rob_idx    = d.rob_idx;
        e.src1_ready = d.src1_ready || woken(d.phy_src1, a, b);
        e.src2_ready = d.src2_ready || woken(d.phy_src2, a, b);
        return e;
    endfunction

    assign granted = grant1_mask | grant2_mask;
    assign allowin = count_q <= CNT_W'(IQ_DEPTH - 2);
    assign take1   = allowin && dispatch1.valid;
    assign take2   = allowin && dispatch2.valid;
    assign entries = queue_q;

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            valid_vec[i] = queue_q[i].valid;
        end
    end

    always_comb begin
        issue_bus_pkg::iq_entry_t e;
        logic [CNT_W-1:0]         kept;
        logic [CNT_W-1:0]         tail2;
        logic [1:0]               gone;
        kept       = '0;
        gone       = '0;
        queue_next = '0;
        // compact survivors down over the granted holes
        for (int i = 0; i < IQ_DEPTH; i++) begin
            e = queue_q[i];
            e.src1_ready = e.src1_ready || woken(e.phy_src1, wb1, wb2);
            e.src2_ready = e.src2_ready || woken(e.phy_src2, wb1, wb2);
            if (e.valid && !granted[i]) begin
                queue_next[i - int'(gone)] = e;
                kept = kept + 1'b1;
            end
            gone = gone + {1'b0, granted[i]};
        end
        // new arrivals go behind the survivors, dispatch1 first
        enq1  = to_entry(dispatch1, wb1, wb2);
        enq2  = to_entry(dispatch2, wb1, wb2);
        tail2 = kept + CNT_W'(take1);
        if (take1) begin
            queue_next[kept] = enq1;
        end
        if (take2) begin
            queue_next[tail2] = enq2;
        end
        count_next = tail2 + CNT_W'(take2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            count_q <= '0;
            for (int i = 0; i < IQ_DEPTH; i++) begin
                queue_q[i].valid <= 1'b0;
            end
        end else begin
            count_q <= count_next;
            queue_q <= queue_next;
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count_q <= CNT_W'(IQ_DEPTH));

    // select must only pick live entries
    grant_hits_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (granted & ~valid_vec) == '0);

endmodule

// ==== logic/issue_select.sv ====
`timescale 1ns/1ns

module issue_select #(
    parameter int IQ_DEPTH = 8
) (
    input  issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] entries,
    output logic [IQ_DEPTH-1:0]                     grant1_mask,
    output logic [IQ_DEPTH-1:0]                     grant2_mask,
    output issue_bus_pkg::issue_slot_t              slot1,
    output issue_bus_pkg::issue_slot_t              slot2
);

    // lane 1: alu1 and branch, lane 2: alu2 and special
    localparam core_cfg_pkg::op_flags_t LANE1_OPS = core_cfg_pkg::op_flags_t'(
        (1 << core_cfg_pkg::OP_ALU1) | (1 << core_cfg_pkg::OP_BR));
    localparam core_cfg_pkg::op_flags_t LANE2_OPS = core_cfg_pkg::op_flags_t'(
        (1 << core_cfg_pkg::OP_ALU2) | (1 << core_cfg_pkg::OP_SP));

    // index 0 is oldest, so first hit wins
    function automatic logic [IQ_DEPTH-1:0] oldest_ready(
        input issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] q,
        input core_cfg_pkg::op_flags_t                 classes
    );
        logic [IQ_DEPTH-1:0] mask;
        logic                found;
        mask  = '0;
        found = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!found && q[i].valid && (q[i].ops & classes) != '0
                && q[i].src1_ready && q[i].src2_ready) begin
                mask[i] = 1'b1;
                found   = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic issue_bus_pkg::issue_slot_t to_slot(
        input issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] q,
        input logic [IQ_DEPTH-1:0]                     mask
    );
        issue_bus_pkg::issue_slot_t s;
        s = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (mask[i]) begin
                s.valid    = 1'b1;
                s.pc       = q[i].pc;
                s.ops      = q[i].ops;
                s.phy_src1 = q[i].phy_src1;
                s.phy_src2 = q[i].phy_src2;
                s.phy_dest = q[i].phy_dest;
                s.rob_idx  = q[i].rob_idx;
            end
        end
        return s;
    endfunction

    assign grant1_mask = oldest_ready(entries, LANE1_OPS);
    assign grant2_mask = oldest_ready(entries, LANE2_OPS);
    assign slot1       = to_slot(entries, grant1_mask);
    assign slot2       = to_slot(entries, grant2_mask);

    // relies on decode setting a single class flag
    grants_exclusive: assert final ($onehot0(grant1_mask) && $onehot0(grant2_mask)
        && (grant1_mask & grant2_mask) == '0);

endmodule

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ns

module issue_stage #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  issue_bus_pkg::dispatch_t dispatch1,
    input  issue_bus_pkg::dispatch_t dispatch2,
    input  issue_bus_pkg::wb_t       wb1,
    input  issue_bus_pkg::wb_t       wb2,
    output logic                     allowin,
    output issue_bus_pkg::exec_op_t  exec1,
    output issue_bus_pkg::exec_op_t  exec2
);

    issue_bus_pkg::iq_entry_t [IQ_DEPTH-1:0] entries;
    logic [IQ_DEPTH-1:0]                     grant1_mask;
    logic [IQ_DEPTH-1:0]                     grant2_mask;
    issue_bus_pkg::issue_slot_t              slot1;
    issue_bus_pkg::issue_slot_t              slot2;

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) issue_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .dispatch1   (dispatch1),
        .dispatch2   (dispatch2),
        .wb1         (wb1),
        .wb2         (wb2),
        .grant1_mask (grant1_mask),
        .grant2_mask (grant2_mask),
        .entries     (entries),
        .allowin     (allowin)
    );

    issue_select #(
        .IQ_DEPTH (IQ_DEPTH)
    ) issue_select_i (
        .entries     (entries),
        .grant1_mask (grant1_mask),
        .grant2_mask (grant2_mask),
        .slot1       (slot1),
        .slot2       (slot2)
    );

    // grants leave the queue at the same edge the slots are registered
    operand_read operand_read_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .slot1 (slot1),
        .slot2 (slot2),
        .wb1   (wb1),
        .wb2   (wb2),
        .exec1 (exec1),
        .exec2 (exec2)
    );

endmodule

// ==== logic/operand_read.sv ====
`timescale 1ns/1ns

module operand_read (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  issue_bus_pkg::issue_slot_t slot1,
    input  issue_bus_pkg::issue_slot_t slot2,
    input  issue_bus_pkg::wb_t         wb1,
    input  issue_bus_pkg::wb_t         wb2,
    output issue_bus_pkg::exec_op_t    exec1,
    output issue_bus_pkg::exec_op_t    exec2
);

    issue_bus_pkg::issue_slot_t   held1;
    issue_bus_pkg::issue_slot_t   held2;
    core_cfg_pkg::phy_reg_t [3:0] raddr;
    core_cfg_pkg::word_t [3:0]    rdata;

    // wb1 wins over wb2, then the register file
    function automatic core_cfg_pkg::word_t operand(
        input core_cfg_pkg::phy_reg_t tag,
        input core_cfg_pkg::word_t    rf_value,
        input issue_bus_pkg::wb_t     a,
        input issue_bus_pkg::wb_t     b
    );
        if (tag == '0) begin
            return '0;
        end
        if (a.rf_we && a.dest == tag) begin
            return a.result;
        end
        if (b.rf_we && b.dest == tag) begin
            return b.result;
        end
        return rf_value;
    endfunction

    function automatic issue_bus_pkg::exec_op_t to_exec(
        input issue_bus_pkg::issue_slot_t s,
        input core_cfg_pkg::word_t        v1,
        input core_cfg_pkg::word_t        v2
    );
        issue_bus_pkg::exec_op_t x;
        x.valid      = s.valid;
        x.pc         = s.pc;
        x.ops        = s.ops;
        x.phy_dest   = s.phy_dest;
        x.rob_idx    = s.rob_idx;
        x.src1_value = v1;
        x.src2_value = v2;
        return x;
    endfunction

    // issue register
    always_ff @(posedge clk) begin
        held1 <= slot1;
        held2 <= slot2;
        if (!rst_n || flush) begin
            held1.valid <= 1'b0;
            held2.valid <= 1'b0;
        end
    end

    assign raddr = {held2.phy_src2, held2.phy_src1, held1.phy_src2, held1.phy_src1};

    phys_regfile phys_regfile_i (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (raddr),
        .rdata (rdata),
        .wb1   (wb1),
        .wb2   (wb2)
    );

    assign exec1 = to_exec(held1,
                           operand(held1.phy_src1, rdata[0], wb1, wb2),
                           operand(held1.phy_src2, rdata[1], wb1, wb2));
    assign exec2 = to_exec(held2,
                           operand(held2.phy_src1, rdata[2], wb1, wb2),
                           operand(held2.phy_src2, rdata[3], wb1, wb2));

endmodule

// ==== logic/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  core_cfg_pkg::phy_reg_t [3:0] raddr,
    output core_cfg_pkg::word_t [3:0]    rdata,
    input  issue_bus_pkg::wb_t           wb1,
    input  issue_bus_pkg::wb_t           wb2
);

    core_cfg_pkg::word_t regs [core_cfg_pkg::PHY_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < core_cfg_pkg::PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb1.rf_we && wb1.dest != '0) begin
                regs[wb1.dest] <= wb1.result;
            end
            if (wb2.rf_we && wb2.dest != '0) begin
                regs[wb2.dest] <= wb2.result;
            end
        end
    end

    // r0 is hardwired
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
        end
    end

    // rename never hands out one tag twice
    no_double_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb1.rf_we && wb2.rf_we && wb1.dest == wb2.dest && wb1.dest != '0));

endmodule

// ==== sim.f ====
logic/core_cfg_pkg.sv
logic/issue_bus_pkg.sv
logic/issue_queue.sv
logic/issue_select.sv
logic/phys_regfile.sv
logic/operand_read.sv
logic/issue_stage.sv
sim/issue_checker.sv
sim/issue_stage_tb.sv

// ==== sim/issue_checker.sv ====
`timescale 1ns/1ns

module issue_checker #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  issue_bus_pkg::dispatch_t dispatch1,
    input  issue_bus_pkg::dispatch_t dispatch2,
    input  issue_bus_pkg::wb_t       wb1,
    input  issue_bus_pkg::wb_t       wb2,
    input  logic                     allowin,
    input  issue_bus_pkg::exec_op_t  exec1,
    input  issue_bus_pkg::exec_op_t  exec2,
    output int                       errors,
    output int                       pending
);

    core_cfg_pkg::word_t      regs [core_cfg_pkg::PHY_REGS];
    issue_bus_pkg::iq_entry_t pend [$];
    issue_bus_pkg::iq_entry_t exp1;
    issue_bus_pkg::iq_entry_t exp2;

    initial begin
        errors  = 0;
        pending = 0;
    end

    function automatic bit ready_now(core_cfg_pkg::phy_reg_t tag);
        return tag == 0 || (wb1.rf_we && wb1.dest == tag) || (wb2.rf_we && wb2.dest == tag);
    endfunction

    function automatic core_cfg_pkg::word_t expected_operand(core_cfg_pkg::phy_reg_t tag);
        if (tag == 0) return 0;
        if (wb1.rf_we && wb1.dest == tag) return wb1.result;
        if (wb2.rf_we && wb2.dest == tag) return wb2.result;
        return regs[tag];
    endfunction

    // oldest ready entry of a lane, -1 if none
    function automatic int oldest_ready(bit lane1);
        bit in_lane;
        for (int i = 0; i < pend.size(); i++) begin
            in_lane = lane1 ? (pend[i].ops[4] || pend[i].ops[3])
                            : (pend[i].ops[2] || pend[i].ops[1]);
            if (in_lane && pend[i].src1_ready && pend[i].src2_ready) return i;
        end
        return -1;
    endfunction

    task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s expected %h got %h", name, want, got);
        end
    endtask

    task automatic compare_lane(string lane, issue_bus_pkg::exec_op_t got,
                                issue_bus_pkg::iq_entry_t want);
        if (want.valid && got.valid !== 1'b1) begin
            errors++;
            $display("%s did not issue the instruction at pc %h", lane, want.pc);
        end else if (!want.valid && got.valid !== 1'b0) begin
            errors++;
            $display("%s issued an unexpected instruction at pc %h", lane, got.pc);
        end else if (want.valid) begin
            check_field({lane, ".pc"}, got.pc, want.pc);
            check_field({lane, ".ops"}, 32'(got.ops), 32'(want.ops));
            check_field({lane, ".phy_dest"}, 32'(got.phy_dest), 32'(want.phy_dest));
            check_field({lane, ".rob_idx"}, 32'(got.rob_idx), 32'(want.rob_idx));
            check_field({lane, ".src1_value"}, got.src1_value, expected_operand(want.phy_src1));
            check_field({lane, ".src2_value"}, got.src2_value, expected_operand(want.phy_src2));
        end
    endtask

    always @(posedge clk) begin
        int                       i1;
        int                       i2;
        bit                       room;
        issue_bus_pkg::iq_entry_t e;
        if (!rst_n) begin
            pend.delete();
            exp1 = '0;
            exp2 = '0;
            for (int r = 0; r < core_cfg_pkg::PHY_REGS; r++) regs[r] = '0;
        end else begin
            compare_lane("exec1", exec1, exp1);
            compare_lane("exec2", exec2, exp2);
            room = pend.size() <= IQ_DEPTH - 2;
            check_field("allowin", 32'(allowin), 32'(room));
            if (flush) begin
                pend.delete();
                exp1 = '0;
                exp2 = '0;
            end else begin
                i1   = oldest_ready(1'b1);
                i2   = oldest_ready(1'b0);
                exp1 = (i1 >= 0) ? pend[i1] : '0;
                exp2 = (i2 >= 0) ? pend[i2] : '0;
                if (i1 > i2) begin
                    pend.delete(i1);
                    if (i2 >= 0) pend.delete(i2);
                end else begin
                    if (i2 >= 0) pend.delete(i2);
                    if (i1 >= 0) pend.delete(i1);
                end
                if (room && dispatch1.valid) pend.push_back(issue_bus_pkg::iq_entry_t'(dispatch1));
                if (room && dispatch2.valid) pend.push_back(issue_bus_pkg::iq_entry_t'(dispatch2));
                // wakeup covers entries entering at this edge too
                for (int i = 0; i < pend.size(); i++) begin
                    e = pend[i];
                    e.src1_ready = e.src1_ready || ready_now(e.phy_src1);
                    e.src2_ready = e.src2_ready || ready_now(e.phy_src2);
                    pend[i] = e;
                end
            end
            if (wb1.rf_we && wb1.dest != 0) regs[wb1.dest] = wb1.result;
            if (wb2.rf_we && wb2.dest != 0) regs[wb2.dest] = wb2.result;
        end
        pending = pend.size();
    end

endmodule

// ==== sim/issue_stage_tb.sv ====
`timescale 1ns/1ns

module issue_stage_tb;

    localparam int IQ_DEPTH = 8;

    typedef struct packed {
        issue_bus_pkg::dispatch_t d1;
        issue_bus_pkg::dispatch_t d2;
        issue_bus_pkg::wb_t       w1;
        issue_bus_pkg::wb_t       w2;
        logic                     flush;
        logic [7:0]               test;
    } row_t;

    logic                     clk;
    logic                     rst_n;
    logic                     flush;
    issue_bus_pkg::dispatch_t dispatch1;
    issue_bus_pkg::dispatch_t dispatch2;
    issue_bus_pkg::wb_t       wb1;
    issue_bus_pkg::wb_t       wb2;
    logic                     allowin;
    issue_bus_pkg::exec_op_t  exec1;
    issue_bus_pkg::exec_op_t  exec2;
    int                       errors;
    int                       pending;

    row_t       rows [$];
    bit         table_ready;
    int         seed;
    int         passed;
    int         failed;
    int         errors_seen;
    logic [7:0] cur_test;
    logic [5:0] sweep;

    // class flags with rf_we in bit 0
    localparam logic [4:0] ALU1 = 5'b10001;
    localparam logic [4:0] BR   = 5'b01000;
    localparam logic [4:0] ALU2 = 5'b00101;
    localparam logic [4:0] SP   = 5'b00010;

    issue_stage #(.IQ_DEPTH(IQ_DEPTH)) issue_stage_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .dispatch1(dispatch1), .dispatch2(dispatch2),
        .wb1(wb1), .wb2(wb2), .allowin(allowin), .exec1(exec1), .exec2(exec2)
    );

    issue_checker #(.IQ_DEPTH(IQ_DEPTH)) issue_checker_i (
        .clk(clk), .rst_n(rst_n), .flush(flush), .dispatch1(dispatch1), .dispatch2(dispatch2),
        .wb1(wb1), .wb2(wb2), .allowin(allowin), .exec1(exec1), .exec2(exec2),
        .errors(errors), .pending(pending)
    );

    function automatic issue_bus_pkg::dispatch_t op(logic [31:0] pc, logic [4:0] ops,
            logic [5:0] s1, logic [5:0] s2, logic r1, logic r2);
        return {1'b1, pc, ops, s1, s2, pc[7:2], pc[7:2], r1, r2};
    endfunction

    function automatic issue_bus_pkg::wb_t wb(logic [5:0] tag, logic [31:0] value);
        return {1'b1, tag, value};
    endfunction

    task automatic add_row(logic [7:0] test, issue_bus_pkg::dispatch_t d1,
            issue_bus_pkg::dispatch_t d2, issue_bus_pkg::wb_t w1, issue_bus_pkg::wb_t w2,
            logic fl);
        rows.push_back({d1, d2, w1, w2, fl, test});
    endtask

    task automatic idle_rows(logic [7:0] test, int n);
        for (int i = 0; i < n; i++) begin
            add_row(test, '0, '0, '0, '0, 1'b0);
        end
    endtask

    task automatic random_row(logic [7:0] test);
        issue_bus_pkg::dispatch_t d [2];
        issue_bus_pkg::wb_t       w [2];
        for (int k = 0; k < 2; k++) begin
            d[k] = op($random(seed) & 32'hfc, 5'b10000 >> ($random(seed) & 3),
                      $random(seed) & 15, $random(seed) & 15, $random(seed), $random(seed));
            d[k].ops[0] = $random(seed);
            d[k].valid  = $random(seed);
            w[k] = wb($random(seed) & 15, $random(seed));
            w[k].rf_we = $random(seed);
        end
        // one tag is never written twice in a cycle
        if (w[0].dest == w[1].dest) begin
            w[1].rf_we = 1'b0;
        end
        add_row(test, d[0], d[1], w[0], w[1], 1'b0);
    endtask

    task automatic build_table();
        add_row(1, '0, '0, wb(3, 32'h1111_aaaa), wb(4, 32'h2222_bbbb), 0);
        add_row(1, op(32'h100, ALU1, 3, 4, 1, 1), op(32'h104, ALU2, 4, 0, 1, 1), '0, '0, 0);
        add_row(1, op(32'h108, BR, 0, 0, 1, 1), op(32'h10c, SP, 3, 3, 1, 1), '0, '0, 0);
        idle_rows(1, 2);
        add_row(2, op(32'h200, ALU1, 5, 3, 0, 1), op(32'h204, ALU2, 6, 0, 0, 1), '0, '0, 0);
        idle_rows(2, 2);
        add_row(2, '0, '0, wb(5, 32'h55), '0, 0);
        idle_rows(2, 1);
        add_row(2, '0, '0, '0, wb(6, 32'h66), 0);
        idle_rows(2, 2);
        add_row(3, op(32'h300, ALU1, 8, 0, 0, 1), op(32'h304, ALU1, 0, 3, 1, 1), '0, '0, 0);
        add_row(3, op(32'h308, BR, 3, 4, 1, 1), op(32'h30c, ALU2, 0, 0, 1, 1), '0, '0, 0);
        add_row(3, '0, '0, wb(8, 32'h88), '0, 0);
        idle_rows(3, 3);
        // exec of this op lines up with the writeback row
        add_row(4, op(32'h400, ALU1, 10, 11, 1, 1), '0, '0, '0, 0);
        idle_rows(4, 1);
        add_row(4, '0, '0, wb(10, 32'hdead_0010), wb(11, 32'hbeef_0011), 0);
        idle_rows(4, 1);
        for (int i = 0; i < 5; i++) begin
            add_row(5, op(32'h500 + 8 * i, ALU1, 12, 0, 0, 1),
                    op(32'h504 + 8 * i, SP, 0, 12, 1, 0), '0, '0, 0);
        end
        idle_rows(5, 4);
        add_row(6, op(32'h600, ALU1, 13, 0, 0, 1), op(32'h604, ALU2, 13, 0, 0, 1), '0, '0, 0);
        add_row(6, op(32'h608, ALU1, 0, 0, 1, 1), '0, '0, '0, 0);
        add_row(6, '0, '0, '0, '0, 1);
        add_row(6, '0, '0, wb(13, 32'h1313), '0, 0);
        idle_rows(6, 3);
        for (int i = 0; i < 60; i++) begin
            random_row(7);
        end
        for (int i = 1; i < 16; i++) begin
            add_row(8, '0, '0, wb(i, 32'h8000 + i), '0, 0);
        end
        idle_rows(8, 4);
    endtask

    task automatic finish_test(logic [7:0] test, int extra);
        int n;
        n = errors - errors_seen + extra;
        if (n == 0) begin
            passed++;
            $display("test %0d ok", test);
        end else begin
            failed++;
            $display("test %0d failed with %0d errors", test, n);
        end
        errors_seen = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + 40) * 4 * 10);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        dispatch1   = '0;
        dispatch2   = '0;
        wb1         = '0;
        wb2         = '0;
        seed        = 32'hd5ae;
        passed      = 0;
        failed      = 0;
        errors_seen = 0;
        sweep       = 6'd1;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        cur_test = rows[0].test;
        for (int r = 0; r < rows.size(); r++) begin
            if (rows[r].test != cur_test) begin
                finish_test(cur_test, 0);
                cur_test = rows[r].test;
            end
            // decode holds; a writeback sweep keeps the queue moving
            while ((rows[r].d1.valid || rows[r].d2.valid) && !allowin) begin
                {dispatch1, dispatch2, flush} = {rows[r].d1, rows[r].d2, 1'b0};
                wb1   = wb(sweep, {26'h5eed, sweep});
                wb2   = '0;
                sweep = (sweep % 15) + 1;
                @(posedge clk);
                #1;
            end
            {dispatch1, dispatch2, wb1, wb2, flush} =
                {rows[r].d1, rows[r].d2, rows[r].w1, rows[r].w2, rows[r].flush};
            @(posedge clk);
            #1;
        end
        {dispatch1, dispatch2, wb1, wb2, flush} = '0;
        // drain the queue and compare the last issue
        for (int c = 0; c < 2 * IQ_DEPTH && pending != 0; c++) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
        if (pending != 0) begin
            $display("%0d instructions never issued", pending);
        end
        finish_test(cur_test, int'(pending != 0));
        $display("passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
